// ==== src/core_defs.svh ====
`ifndef CORE_DEFS_SVH
`define CORE_DEFS_SVH

// datapath and instruction widths
`define XLEN     32
`define INST_LEN 32

`define REG_NUM  32
`define RESET_PC 32'h0000_0000
`define A0_IDX   10

`endif

// ==== src/core_pkg.sv ====
`include "core_defs.svh"

package core_pkg;

    typedef logic [$clog2(`REG_NUM)-1:0] reg_idx_t;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_SLL,
        ALU_SLT,
        ALU_SLTU,
        ALU_XOR,
        ALU_SRL,
        ALU_SRA,
        ALU_OR,
        ALU_AND,
        // lui passes the immediate through
        ALU_PASS_B
    } alu_op_e;

    typedef enum logic [1:0] {
        BR_NONE,
        BR_BEQ,
        BR_BNE,
        BR_JAL
    } br_kind_e;

    typedef struct packed {
        logic [`XLEN-1:0]     pc;
        logic [`INST_LEN-1:0] inst;
    } if_id_t;

    typedef struct packed {
        logic [`XLEN-1:0]     pc;
        logic [`INST_LEN-1:0] inst;
        logic [`XLEN-1:0]     rs1_val;
        logic [`XLEN-1:0]     rs2_val;
        logic [`XLEN-1:0]     imm;
        reg_idx_t             rs1_idx;
        reg_idx_t             rs2_idx;
        reg_idx_t             rd_idx;
        alu_op_e              alu_op;
        br_kind_e             br_kind;
        logic                 we;
        logic                 use_imm;
    } id_ex_t;

    typedef struct packed {
        logic [`XLEN-1:0]     pc;
        logic [`INST_LEN-1:0] inst;
        logic [`XLEN-1:0]     result;
        reg_idx_t             rd_idx;
        logic                 we;
    } ex_wb_t;

endpackage

// ==== src/wb_if.sv ====
`include "core_defs.svh"

interface wb_if import core_pkg::*;;
    logic                 valid;
    logic                 we;
    reg_idx_t             rd;
    logic [`XLEN-1:0]     data;
    logic [`XLEN-1:0]     pc;
    logic [`INST_LEN-1:0] instr;

    modport source (output valid, we, rd, data, pc, instr);
    modport sink   (input  valid, we, rd, data, pc, instr);
endinterface

// ==== src/fetch_unit.sv ====
`include "core_defs.svh"

module fetch_unit import core_pkg::*; (
    input  logic             clk,
    input  logic             rst_i,
    input  logic             redirect_i,
    input  logic [`XLEN-1:0] target_i,
    input  logic [`XLEN-1:0] sram_rdata_i,
    input  logic             sram_data_valid_i,
    output logic [`XLEN-1:0] sram_addr_o,
    output logic             sram_ren_o,
    output logic             fetch_valid_o,
    output if_id_t           fetch_o
);
    typedef enum logic [1:0] {S_IDLE, S_WAIT, S_DROP} state_e;

    state_e           state_q;
    logic [`XLEN-1:0] pc_q;
    logic [`XLEN-1:0] addr_q;

    always_ff @(posedge clk) begin
        if (rst_i) begin
            state_q <= S_IDLE;
            pc_q    <= `RESET_PC;
        end else begin
            case (state_q)
                S_IDLE: state_q <= S_WAIT;
                S_WAIT: begin
                    if (redirect_i) begin
                        pc_q    <= target_i;
                        state_q <= sram_data_valid_i ? S_IDLE : S_DROP;
                    end else if (sram_data_valid_i) begin
                        pc_q    <= addr_q + 'd4;
                        state_q <= S_IDLE;
                    end
                end
                S_DROP: begin
                    if (redirect_i) begin
                        pc_q <= target_i;
                    end
                    // stale word arrives and is thrown away
                    if (sram_data_valid_i) begin
                        state_q <= S_IDLE;
                    end
                end
                default: state_q <= S_IDLE;
            endcase
        end
    end

    // request address held while the request is open
    always_ff @(posedge clk) begin
        if (state_q == S_IDLE) begin
            addr_q <= redirect_i ? target_i : pc_q;
        end
    end

    assign sram_ren_o    = (state_q != S_IDLE);
    assign sram_addr_o   = addr_q;
    assign fetch_valid_o = (state_q == S_WAIT) && sram_data_valid_i && !redirect_i;
    assign fetch_o.pc    = addr_q;
    assign fetch_o.inst  = sram_rdata_i;

endmodule

// ==== src/pipe_reg.sv ====
module pipe_reg #(
    parameter type T = logic
) (
    input  logic clk,
    input  logic rst_i,
    input  logic flush_i,
    input  logic valid_i,
    input  T     data_i,
    output logic valid_o,
    output T     data_o
);
    logic valid_q;
    T     data_q;

    always_ff @(posedge clk) begin
        if (rst_i || flush_i) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= valid_i;
        end
    end

    // payload follows the input every cycle
    always_ff @(posedge clk) begin
        data_q <= data_i;
    end

    assign valid_o = valid_q;
    assign data_o  = data_q;

endmodule

// ==== src/decode_stage.sv ====
`include "core_defs.svh"

module decode_stage import core_pkg::*; (
    input  logic             clk,
    input  logic             valid_i,
    input  if_id_t           inst_i,
    wb_if.sink               wb,
    output id_ex_t           dec_o,
    output logic [`XLEN-1:0] reg_a0_o
);
    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_JAL    = 7'b1101111;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;

    logic [`XLEN-1:0]     regs [`REG_NUM];
    logic [`INST_LEN-1:0] ins;
    reg_idx_t             rs1;
    reg_idx_t             rs2;
    logic                 wb_wr;
    alu_op_e              alu_op;
    br_kind_e             br_kind;
    logic [`XLEN-1:0]     imm;
    logic                 we;
    logic                 use_imm;

    function automatic alu_op_e alu_decode(input logic [2:0] f3, input logic alt);
        case (f3)
            3'b000:  return alt ? ALU_SUB : ALU_ADD;
            3'b001:  return ALU_SLL;
            3'b010:  return ALU_SLT;
            3'b011:  return ALU_SLTU;
            3'b100:  return ALU_XOR;
            3'b101:  return alt ? ALU_SRA : ALU_SRL;
            3'b110:  return ALU_OR;
            default: return ALU_AND;
        endcase
    endfunction

    assign ins   = inst_i.inst;
    assign rs1   = ins[19:15];
    assign rs2   = ins[24:20];
    assign wb_wr = wb.valid && wb.we && (wb.rd != '0);

    always_ff @(posedge clk) begin
        if (wb_wr) begin
            regs[wb.rd] <= wb.data;
        end
    end

    always_comb begin
        alu_op  = ALU_ADD;
        br_kind = BR_NONE;
        imm     = {{20{ins[31]}}, ins[31:20]};
        we      = 1'b0;
        use_imm = 1'b0;
        case (ins[6:0])
            OPC_OP: begin
                we     = 1'b1;
                alu_op = alu_decode(ins[14:12], ins[30]);
            end
            OPC_OP_IMM: begin
                we      = 1'b1;
                use_imm = 1'b1;
                // bit 30 is part of the immediate except for srai
                alu_op  = alu_decode(ins[14:12], ins[30] && (ins[14:12] == 3'b101));
            end
            OPC_LUI: begin
                we      = 1'b1;
                use_imm = 1'b1;
                alu_op  = ALU_PASS_B;
                imm     = {ins[31:12], 12'b0};
            end
            OPC_JAL: begin
                we      = 1'b1;
                br_kind = BR_JAL;
                imm     = {{12{ins[31]}}, ins[19:12], ins[20], ins[30:21], 1'b0};
            end
            OPC_BRANCH: begin
                imm = {{20{ins[31]}}, ins[7], ins[30:25], ins[11:8], 1'b0};
                if (ins[14:12] == 3'b000) begin
                    br_kind = BR_BEQ;
                end else if (ins[14:12] == 3'b001) begin
                    br_kind = BR_BNE;
                end
            end
            default: ;
        endcase
    end

    always_comb begin
        dec_o.pc      = inst_i.pc;
        dec_o.inst    = ins;
        // x0 reads zero
        // same-cycle writeback wins over the array
        dec_o.rs1_val = (rs1 == '0) ? '0 : (wb_wr && wb.rd == rs1) ? wb.data : regs[rs1];
        dec_o.rs2_val = (rs2 == '0) ? '0 : (wb_wr && wb.rd == rs2) ? wb.data : regs[rs2];
        dec_o.imm     = imm;
        dec_o.rs1_idx = rs1;
        dec_o.rs2_idx = rs2;
        dec_o.rd_idx  = ins[11:7];
        dec_o.alu_op  = alu_op;
        dec_o.br_kind = valid_i ? br_kind : BR_NONE;
        dec_o.we      = valid_i && we;
        dec_o.use_imm = use_imm;
    end

    assign reg_a0_o = regs[`A0_IDX];

endmodule

// ==== src/exec_stage.sv ====
`include "core_defs.svh"

module exec_stage import core_pkg::*; (
    input  logic             valid_i,
    input  id_ex_t           dec_i,
    wb_if.sink               wb,
    output ex_wb_t           res_o,
    output logic             redirect_o,
    output logic [`XLEN-1:0] target_o
);
    logic                       wb_wr;
    logic                       fwd_a;
    logic                       fwd_b;
    logic [`XLEN-1:0]           op_a;
    logic [`XLEN-1:0]           rs2_val;
    logic [`XLEN-1:0]           op_b;
    logic [$clog2(`XLEN)-1:0]   shamt;
    logic [`XLEN-1:0]           alu_res;
    logic                       taken;

    // forward from the instruction currently in writeback
    assign wb_wr   = wb.valid && wb.we && (wb.rd != '0);
    assign fwd_a   = wb_wr && (wb.rd == dec_i.rs1_idx);
    assign fwd_b   = wb_wr && (wb.rd == dec_i.rs2_idx);
    assign op_a    = fwd_a ? wb.data : dec_i.rs1_val;
    assign rs2_val = fwd_b ? wb.data : dec_i.rs2_val;
    assign op_b    = dec_i.use_imm ? dec_i.imm : rs2_val;
    assign shamt   = op_b[$clog2(`XLEN)-1:0];

    always_comb begin
        case (dec_i.alu_op)
            ALU_ADD:    alu_res = op_a + op_b;
            ALU_SUB:    alu_res = op_a - op_b;
            ALU_SLL:    alu_res = op_a << shamt;
            ALU_SLT:    alu_res = {31'b0, $signed(op_a) < $signed(op_b)};
            ALU_SLTU:   alu_res = {31'b0, op_a < op_b};
            ALU_XOR:    alu_res = op_a ^ op_b;
            ALU_SRL:    alu_res = op_a >> shamt;
            ALU_SRA:    alu_res = $signed(op_a) >>> shamt;
            ALU_OR:     alu_res = op_a | op_b;
            ALU_AND:    alu_res = op_a & op_b;
            ALU_PASS_B: alu_res = op_b;
            default:    alu_res = '0;
        endcase
    end

    always_comb begin
        case (dec_i.br_kind)
            BR_BEQ:  taken = (op_a == rs2_val);
            BR_BNE:  taken = (op_a != rs2_val);
            BR_JAL:  taken = 1'b1;
            default: taken = 1'b0;
        endcase
    end

    assign redirect_o = valid_i && taken;
    assign target_o   = dec_i.pc + dec_i.imm;

    always_comb begin
        res_o.pc     = dec_i.pc;
        res_o.inst   = dec_i.inst;
        // jal links pc+4
        res_o.result = (dec_i.br_kind == BR_JAL) ? dec_i.pc + 'd4 : alu_res;
        res_o.rd_idx = dec_i.rd_idx;
        res_o.we     = dec_i.we;
    end

endmodule

// ==== src/core_top.sv ====
`include "core_defs.svh"

module core_top import core_pkg::*; (
    input  logic                 clk,
    input  logic                 rst_i,
    input  logic [`XLEN-1:0]     sram_rdata_i,
    input  logic                 sram_data_valid_i,
    output logic [`XLEN-1:0]     sram_addr_o,
    output logic                 sram_ren_o,
    output logic                 retire_valid_o,
    output logic [`XLEN-1:0]     retire_pc_o,
    output logic [`INST_LEN-1:0] retire_instr_o,
    output logic [`XLEN-1:0]     reg_a0_o
);
    logic             redirect;
    logic [`XLEN-1:0] target;
    logic             fetch_valid;
    if_id_t           fetch_pl;
    logic             id_valid;
    if_id_t           id_pl;
    id_ex_t           dec_pl;
    logic             ex_valid;
    id_ex_t           ex_pl;
    ex_wb_t           res_pl;
    logic             wb_valid;
    ex_wb_t           wb_pl;

    wb_if wb_bus ();

    fetch_unit fetch_u (
        .clk               (clk),
        .rst_i             (rst_i),
        .redirect_i        (redirect),
        .target_i          (target),
        .sram_rdata_i      (sram_rdata_i),
        .sram_data_valid_i (sram_data_valid_i),
        .sram_addr_o       (sram_addr_o),
        .sram_ren_o        (sram_ren_o),
        .fetch_valid_o     (fetch_valid),
        .fetch_o           (fetch_pl)
    );

    pipe_reg #(.T(if_id_t)) if_id_u (
        .clk (clk), .rst_i (rst_i), .flush_i (redirect),
        .valid_i (fetch_valid), .data_i (fetch_pl), .valid_o (id_valid), .data_o (id_pl)
    );

    decode_stage decode_u (
        .clk      (clk),
        .valid_i  (id_valid),
        .inst_i   (id_pl),
        .wb       (wb_bus.sink),
        .dec_o    (dec_pl),
        .reg_a0_o (reg_a0_o)
    );

    pipe_reg #(.T(id_ex_t)) id_ex_u (
        .clk (clk), .rst_i (rst_i), .flush_i (redirect),
        .valid_i (id_valid), .data_i (dec_pl), .valid_o (ex_valid), .data_o (ex_pl)
    );

    exec_stage exec_u (
        .valid_i    (ex_valid),
        .dec_i      (ex_pl),
        .wb         (wb_bus.sink),
        .res_o      (res_pl),
        .redirect_o (redirect),
        .target_o   (target)
    );

    // the redirecting instruction itself still retires
    pipe_reg #(.T(ex_wb_t)) ex_wb_u (
        .clk (clk), .rst_i (rst_i), .flush_i (1'b0),
        .valid_i (ex_valid), .data_i (res_pl), .valid_o (wb_valid), .data_o (wb_pl)
    );

    assign wb_bus.valid = wb_valid;
    assign wb_bus.we    = wb_pl.we;
    assign wb_bus.rd    = wb_pl.rd_idx;
    assign wb_bus.data  = wb_pl.result;
    assign wb_bus.pc    = wb_pl.pc;
    assign wb_bus.instr = wb_pl.inst;

    assign retire_valid_o = wb_bus.valid;
    assign retire_pc_o    = wb_bus.pc;
    assign retire_instr_o = wb_bus.instr;

endmodule

// ==== verif/core_chk.sv ====
`include "core_defs.svh"

module core_chk (
    input logic             clk,
    input logic             rst_i,
    input logic             ren_i,
    input logic             dvalid_i,
    input logic [`XLEN-1:0] addr_i,
    input logic             ret_valid_i,
    input logic [`XLEN-1:0] ret_pc_i
);
    int unsigned fail_count = 0;
    logic        in_reset_q = 1'b0;

    // high once reset has been seen at an edge
    always @(posedge clk) begin
        in_reset_q <= rst_i;
    end

    // an open request keeps its address until the response
    addr_held: assert property (@(posedge clk) disable iff (rst_i)
        ren_i && !dvalid_i |=> ren_i && $stable(addr_i))
        else begin
            $error("sram request dropped or address moved before the response");
            fail_count++;
        end

    reset_quiet: assert property (@(posedge clk)
        rst_i && in_reset_q |-> !ren_i && !ret_valid_i)
        else begin
            $error("sram request or retire active during reset");
            fail_count++;
        end

    pc_aligned: assert property (@(posedge clk) disable iff (rst_i)
        ret_valid_i |-> ret_pc_i[1:0] == 2'b00)
        else begin
            $error("retired pc is not word aligned");
            fail_count++;
        end

endmodule

// ==== verif/core_tb.sv ====
`include "core_defs.svh"

module core_tb;
    localparam int GOLD_WORDS  = 256;
    localparam int PROG_WORDS  = 64;
    localparam int HDR_IDX     = 64;
    localparam int TRACE_IDX   = 72;
    localparam int RETIRE_WAIT = 100;

    logic                 clk               = 1'b0;
    logic                 rst_i             = 1'b1;
    logic [`XLEN-1:0]     sram_rdata_i      = '0;
    logic                 sram_data_valid_i = 1'b0;
    logic [`XLEN-1:0]     sram_addr_o;
    logic                 sram_ren_o;
    logic                 retire_valid_o;
    logic [`XLEN-1:0]     retire_pc_o;
    logic [`INST_LEN-1:0] retire_instr_o;
    logic [`XLEN-1:0]     reg_a0_o;

    // program words, header and retire trace share one image
    logic [31:0] gold [GOLD_WORDS];
    logic [31:0] lfsr = 32'h1963;
    logic [2:0]  lat_left = 3'd0;
    logic [2:0]  lat;
    logic        b0;
    logic        b1;
    int          n_retire;

    core_top DUT (.*);

    bind core_top core_chk chk_u (
        .clk         (clk),
        .rst_i       (rst_i),
        .ren_i       (sram_ren_o),
        .dvalid_i    (sram_data_valid_i),
        .addr_i      (sram_addr_o),
        .ret_valid_i (retire_valid_o),
        .ret_pc_i    (retire_pc_o)
    );

    always #20 clk = ~clk;

    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    // custom-0 opcode keeps unmapped words as no-ops
    function automatic logic [31:0] fill_word(input logic [31:0] addr);
        return {addr[31:7] ^ addr[24:0], 7'b0001011};
    endfunction

    function automatic logic [31:0] sram_word(input logic [31:0] addr);
        if (addr < 32'd256) begin
            return gold[addr[9:2]];
        end
        return fill_word(addr);
    endfunction

    task automatic take_bit(output logic b);
        b = lfsr[0];
        lfsr = lfsr_step(lfsr);
    endtask

    task automatic fail_run(input string why);
        $display("%s", why);
        $display("Simulation finished: FAIL");
        $fatal(1, "run stopped");
    endtask

    task automatic check_eq(input logic [31:0] got, input logic [31:0] exp, input string what);
        if (got !== exp) begin
            fail_run($sformatf("Error: %0t: %s is %h, expected %h", $time, what, got, exp));
        end
    endtask

    task automatic wait_retire(input int idx);
        int cycles;
        cycles = 0;
        @(negedge clk);
        while (!retire_valid_o) begin
            if (cycles == RETIRE_WAIT) begin
                fail_run($sformatf("timeout: retire record %0d never came", idx));
            end else begin
                cycles++;
                @(negedge clk);
            end
        end
    endtask

    // sram model with 1 to 4 cycles of latency per request
    always @(posedge clk) begin
        sram_data_valid_i <= 1'b0;
        if (rst_i) begin
            lat_left <= 3'd0;
        end else if (sram_ren_o && !sram_data_valid_i) begin
            if (lat_left == 3'd0) begin
                take_bit(b0);
                take_bit(b1);
                lat = {1'b0, b1, b0} + 3'd1;
            end else begin
                lat = lat_left;
            end
            if (lat == 3'd1) begin
                sram_data_valid_i <= 1'b1;
                sram_rdata_i      <= sram_word(sram_addr_o);
                lat_left          <= 3'd0;
            end else begin
                lat_left <= lat - 3'd1;
            end
        end
    end

    always @(negedge clk) begin
        if (DUT.chk_u.fail_count != 0) begin
            fail_run("a bound assertion on the DUT failed");
        end
    end

    initial begin
        for (int i = 0; i < PROG_WORDS; i++) begin
            gold[i] = fill_word(32'(i) << 2);
        end
        for (int i = PROG_WORDS; i < GOLD_WORDS; i++) begin
            gold[i] = '0;
        end
        $readmemh("verif/core_golden.hex", gold);
        n_retire = gold[HDR_IDX];
        if (n_retire == 0) begin
            fail_run("golden file holds no retire records");
        end
        repeat (10) @(posedge clk);
        rst_i <= 1'b0;
        for (int k = 0; k < n_retire; k++) begin
            wait_retire(k);
            check_eq(retire_pc_o, gold[TRACE_IDX + 2 * k], "retire pc");
            check_eq(retire_instr_o, gold[TRACE_IDX + 2 * k + 1], "retire instruction");
        end
        // last write to a0 retired well before the final jal
        check_eq(reg_a0_o, gold[HDR_IDX + 1], "final a0");
        if (DUT.chk_u.fail_count == 0) begin
            $display("Simulation finished: PASS");
            $finish;
        end else begin
            fail_run("a bound assertion on the DUT failed");
        end
    end

endmodule

// ==== files.f ====
+incdir+src
src/core_pkg.sv
src/wb_if.sv
src/fetch_unit.sv
src/pipe_reg.sv
src/decode_stage.sv
src/exec_stage.sv
src/core_top.sv
verif/core_chk.sv
verif/core_tb.sv

// ==== Makefile ====
SIM := obj_dir/Vcore_tb

.PHONY: all run clean

all: $(SIM)

# rebuilt only when a source or the file list changes
$(SIM): files.f $(wildcard src/*.sv src/*.svh verif/*.sv)
	verilator --binary --assert -j 0 --top-module core_tb -f files.f

run: $(SIM)
	./$(SIM) +verilator+error+limit+10 | tee sim.log
	grep -q "Simulation finished: PASS" sim.log

clean:
	rm -rf obj_dir sim.log

// ==== verif/core_golden.hex ====
// 32-bit words. @00 program image, @40 retire count and final a0,
// @48 retire trace as pc then instruction, in retire order
@00
ff800093 00b08113 4020d1b3 0020a233
0020b2b3 4010d313 ff90a393 fff0b413
123454b7 0f04c513 401105b3 00411633
0020d6b3 0014f733 00d54533 00820463
7ff00513 00821463 00500793 00079663
00100513 00000793 00c000ef 00150513
00200513 0000050b 05550013 00150533
00618833 007288b3 41180833 00c588b3
01184833 00e80833 01050533 0000006f
@40
0000001f 1fffff56
@48
00000000 ff800093 00000004 00b08113
00000008 4020d1b3 0000000c 0020a233
00000010 0020b2b3 00000014 4010d313
00000018 ff90a393 0000001c fff0b413
00000020 123454b7 00000024 0f04c513
00000028 401105b3 0000002c 00411633
00000030 0020d6b3 00000034 0014f733
00000038 00d54533 0000003c 00820463
00000044 00821463 00000048 00500793
0000004c 00079663 00000058 00c000ef
00000064 0000050b 00000068 05550013
0000006c 00150533 00000070 00618833
00000074 007288b3 00000078 41180833
0000007c 00c588b3 00000080 01184833
00000084 00e80833 00000088 01050533
0000008c 0000006f
